// File: hdl/motorPkg.sv
package motorPkg;

    // six-step commutation walks through six sectors per electrical turn
    localparam int SECTOR_COUNT = 6;

    // three bits are enough to index the six sectors
    localparam int SECTOR_W = 3;

    // duty command width, in clock cycles of on-time per frame
    localparam int DUTY_W = 8;

    // step length command width, in clock cycles per commutation step
    localparam int STEP_W = 16;

    // one PWM frame spans this many clock cycles
    localparam int PWM_PERIOD = 64;

    // the frame counter runs from zero up to PWM_PERIOD minus one
    localparam int FRAME_W = $clog2(PWM_PERIOD);

    // the on-time needs one more bit than the counter so that a full frame fits
    localparam int ON_W = FRAME_W + 1;

    // shorter pulses than this are dropped, the gate driver cannot switch that fast
    localparam int PWM_MIN_ON = 8;

    // all six gates stay off this many cycles after a commutation
    localparam int DEAD_CYCLES = 4;

    // width of the dead-time down-counter
    localparam int DEAD_W = 3;

endpackage

// File: hdl/driveIf.sv
`timescale 1ns/1ps

// shared drive bundle between the control FSM, the PWM generator and the phase driver
interface driveIf import motorPkg::*; ();

    // sector index, stepped by the control FSM
    logic [SECTOR_W-1:0] sector;
    // single-cycle pulse on every sector change
    logic                commutate;
    // level, high while the motor runs
    logic                outputEnable;
    // chopping signal for the active high-side switch
    logic                pwm;

    modport ctrl (output sector, output commutate, output outputEnable);

    modport pwmGen (input commutate, input outputEnable, output pwm);

    // the phase driver only listens
    modport phase (input sector, input commutate, input outputEnable, input pwm);

endinterface

// File: hdl/commutationTimer.sv
`timescale 1ns/1ps

// step period down-counter, one stepLast pulse per commutation step
module commutationTimer import motorPkg::*; (
    input  logic              clk,
    input  logic              nRst,
    input  logic              timerRun,
    input  logic [STEP_W-1:0] stepLen,
    output logic              stepLast
);

    // remaining cycles in the current step
    logic [STEP_W-1:0] count;

    // the step ends in the cycle the count sits at zero
    logic countZero;

    assign countZero = (count == '0);

    // stepLast is only meaningful while the timer is allowed to run
    assign stepLast = timerRun && countZero;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            count <= '0;
        end else if (!timerRun) begin
            // while stopped the counter tracks the command, so a new
            // step length is picked up the moment the motor starts
            count <= stepLen;
        end else if (countZero) begin
            // reload after the last cycle of the step
            // a step therefore lasts stepLen plus one cycles
            count <= stepLen;
        end else begin
            count <= count - 1'b1;
        end
    end

endmodule

// File: hdl/pwmGenerator.sv
`timescale 1ns/1ps

// frame counter with a latched duty
// each frame starts with its off portion and ends with its on portion
module pwmGenerator import motorPkg::*; (
    input  logic              clk,
    input  logic              nRst,
    input  logic [DUTY_W-1:0] duty,
    driveIf.pwmGen            drive
);

    // position inside the current frame
    logic [FRAME_W-1:0] frameCnt;

    // duty captured at the start of the frame
    logic [DUTY_W-1:0] dutyReg;

    // effective on-time and the off-time that precedes it
    logic [ON_W-1:0] onLen;
    logic [ON_W-1:0] offLen;

    // the last cycle of a frame, the next edge starts a new one
    logic frameEnd;

    assign frameEnd = (frameCnt == FRAME_W'(PWM_PERIOD - 1));

    // clamp the duty to a full frame and drop pulses below the minimum on-time
    always_comb begin
        if (dutyReg < DUTY_W'(PWM_MIN_ON)) begin
            onLen = '0;
        end else if (dutyReg > DUTY_W'(PWM_PERIOD)) begin
            onLen = ON_W'(PWM_PERIOD);
        end else begin
            onLen = ON_W'(dutyReg);
        end
    end

    // with no on portion the off time is a whole frame and the compare never hits
    assign offLen = ON_W'(PWM_PERIOD) - onLen;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            frameCnt <= '0;
            dutyReg  <= '0;
        end else if (!drive.outputEnable || drive.commutate || frameEnd) begin
            // stopped output holds the frame at its start
            // commutation restarts the frame the same way the frame end does,
            // and every new frame takes the current duty command
            frameCnt <= '0;
            dutyReg  <= duty;
        end else begin
            frameCnt <= frameCnt + 1'b1;
        end
    end

    // the switch turns on once the off portion has elapsed
    // and it is never on while the outputs are disabled
    assign drive.pwm = drive.outputEnable && ({1'b0, frameCnt} >= offLen);

endmodule

// File: hdl/phaseDriver.sv
`timescale 1ns/1ps

// six-step gate table with dead time, gates are registered
module phaseDriver import motorPkg::*; (
    input  logic   clk,
    input  logic   nRst,
    driveIf.phase  drive,
    output logic [2:0] highGate,
    output logic [2:0] lowGate
);

    // remaining all-off cycles after a commutation
    logic [DEAD_W-1:0] deadCnt;
    logic [DEAD_W-1:0] deadNext;

    // one-hot phase selection for the current sector
    logic [2:0] highSel;
    logic [2:0] lowSel;

    // the high phase is sector / 2, the low phase is one or two phases further on
    always_comb begin
        case (drive.sector)
            SECTOR_W'(0): begin highSel = 3'b001; lowSel = 3'b010; end
            SECTOR_W'(1): begin highSel = 3'b001; lowSel = 3'b100; end
            SECTOR_W'(2): begin highSel = 3'b010; lowSel = 3'b100; end
            SECTOR_W'(3): begin highSel = 3'b010; lowSel = 3'b001; end
            SECTOR_W'(4): begin highSel = 3'b100; lowSel = 3'b001; end
            SECTOR_W'(5): begin highSel = 3'b100; lowSel = 3'b010; end
            // sector codes six and seven never occur, keep everything off
            default: begin highSel = 3'b000; lowSel = 3'b000; end
        endcase
    end

    // the gates open on the edge where the counter reaches zero
    // so a load of DEAD_CYCLES gives exactly DEAD_CYCLES off cycles
    always_comb begin
        if (drive.commutate) begin
            deadNext = DEAD_W'(DEAD_CYCLES);
        end else if (deadCnt != '0) begin
            deadNext = deadCnt - 1'b1;
        end else begin
            deadNext = '0;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            deadCnt  <= '0;
            highGate <= '0;
            lowGate  <= '0;
        end else begin
            deadCnt <= deadNext;
            if (drive.outputEnable && !drive.commutate && deadNext == '0) begin
                // high side is chopped, low side conducts for the whole step
                highGate <= highSel & {3{drive.pwm}};
                lowGate  <= lowSel;
            end else begin
                highGate <= '0;
                lowGate  <= '0;
            end
        end
    end

endmodule

// File: hdl/motorCtrl.sv
`timescale 1ns/1ps

// idle/run FSM, owns the direction latch and the sector index
module motorCtrl import motorPkg::*; (
    input  logic  clk,
    input  logic  nRst,
    input  logic  enable,
    input  logic  direction,
    input  logic  stepLast,
    output logic  timerRun,
    output logic  running,
    driveIf.ctrl  drive
);

    // direction captured at start, ignored afterwards until the next start
    logic dirLatch;

    // sector register and the neighbours it can move to
    logic [SECTOR_W-1:0] sectorReg;
    logic [SECTOR_W-1:0] sectorUp;
    logic [SECTOR_W-1:0] sectorDown;

    // pulse register for the interface
    logic commutateReg;

    // step forward and backward modulo six
    always_comb begin
        if (sectorReg == SECTOR_W'(SECTOR_COUNT - 1)) begin
            sectorUp = '0;
        end else begin
            sectorUp = sectorReg + 1'b1;
        end
        if (sectorReg == '0) begin
            sectorDown = SECTOR_W'(SECTOR_COUNT - 1);
        end else begin
            sectorDown = sectorReg - 1'b1;
        end
    end

    // the run state itself is the running flop, idle when low
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            running  <= 1'b0;
            dirLatch <= 1'b0;
        end else if (!running) begin
            if (enable) begin
                running  <= 1'b1;
                dirLatch <= direction;
            end
        end else if (!enable) begin
            running <= 1'b0;
        end
    end

    // stepLast only pulses while the timer runs, that is while running is high
    // the sector is kept over a stop so that a restart continues from it
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            sectorReg    <= '0;
            commutateReg <= 1'b0;
        end else begin
            commutateReg <= stepLast;
            if (stepLast) begin
                sectorReg <= dirLatch ? sectorDown : sectorUp;
            end
        end
    end

    // timer and output stage both follow the run state
    assign timerRun           = running;
    assign drive.outputEnable = running;
    assign drive.commutate    = commutateReg;
    assign drive.sector       = sectorReg;

endmodule

// File: hdl/motorPwmTop.sv
`timescale 1ns/1ps

// power-stage timing top, control, timer, PWM and phase driver
module motorPwmTop import motorPkg::*; (
    input  logic                clk,
    input  logic                nRst,
    input  logic                enable,
    input  logic                direction,
    input  logic [DUTY_W-1:0]   duty,
    input  logic [STEP_W-1:0]   stepLen,
    output logic [2:0]          highGate,
    output logic [2:0]          lowGate,
    output logic                running,
    output logic [SECTOR_W-1:0] sector
);

    // step timing between the control FSM and the timer
    logic timerRun;
    logic stepLast;

    // sector, commutate, output enable and pwm
    driveIf drive ();

    commutationTimer uTimer (
        .clk      (clk),
        .nRst     (nRst),
        .timerRun (timerRun),
        .stepLen  (stepLen),
        .stepLast (stepLast)
    );

    motorCtrl uCtrl (
        .clk       (clk),
        .nRst      (nRst),
        .enable    (enable),
        .direction (direction),
        .stepLast  (stepLast),
        .timerRun  (timerRun),
        .running   (running),
        .drive     (drive.ctrl)
    );

    pwmGenerator uPwm (
        .clk   (clk),
        .nRst  (nRst),
        .duty  (duty),
        .drive (drive.pwmGen)
    );

    phaseDriver uPhase (
        .clk      (clk),
        .nRst     (nRst),
        .drive    (drive.phase),
        .highGate (highGate),
        .lowGate  (lowGate)
    );

    // sector is visible at the top for monitoring
    assign sector = drive.sector;

endmodule

// File: testbench/clockGen.sv
`timescale 1ns/1ps

// 40 ns clock, reset held low for the first eight cycles
module clockGen (
    output logic clk,
    output logic nRst
);

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a falling edge so the first active edge sees a clean reset
    initial begin
        nRst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        nRst = 1'b1;
    end

endmodule

// File: testbench/motorPwm_props.sv
`timescale 1ns/1ps

// gate safety properties of the power stage
module motorPwmProps (
    input logic       clk,
    input logic       nRst,
    input logic [2:0] highGate,
    input logic [2:0] lowGate,
    input logic       running
);

    // running count of property failures
    int assertFails = 0;

    // a phase leg must never conduct through both of its switches
    noShootThrough: assert property (@(posedge clk) disable iff (!nRst)
        (highGate & lowGate) == 3'b000)
        else begin
            $error("high and low gate of one phase are on together");
            assertFails++;
        end

    // gates trail running by one cycle when the motor stops
    offWhileStopped: assert property (@(posedge clk) disable iff (!nRst)
        (!running && !$past(running)) |-> (highGate == 3'b000 && lowGate == 3'b000))
        else begin
            $error("gates on while the motor is stopped");
            assertFails++;
        end

endmodule

bind motorPwmTop motorPwmProps props (
    .clk      (clk),
    .nRst     (nRst),
    .highGate (highGate),
    .lowGate  (lowGate),
    .running  (running)
);

// File: testbench/motorPwmTb.sv
`timescale 1ns/1ps

// random stimulus against a cycle model of the six-step power stage
module motorPwmTb import motorPkg::*; ();

    localparam int SEED = 35723;
    localparam int MAX_STEP = 400;
    // all tests together take fewer commutation steps than this
    localparam int TOTAL_STEPS = 26;
    localparam int WATCH_CYCLES = TOTAL_STEPS * (MAX_STEP + 1) + 1000;
    localparam int WAIT_LIMIT = 2 * (MAX_STEP + 1) + 16;

    logic clk, nRst, enable, direction, running;
    logic [DUTY_W-1:0] duty;
    logic [STEP_W-1:0] stepLen;
    logic [2:0] highGate, lowGate;
    logic [SECTOR_W-1:0] sector;

    logic [31:0] rngState = SEED;
    int errCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    // property failures already added to errCount
    int assertSeen = 0;

    // model state, advanced on every rising edge
    int mTimer, mFrame, mDuty, mDead, mSector;
    logic mRunning, mDir, mCommutate;
    logic [2:0] mHigh, mLow;

    clockGen uClock (.clk(clk), .nRst(nRst));

    motorPwmTop dut (
        .clk(clk), .nRst(nRst), .enable(enable), .direction(direction), .duty(duty),
        .stepLen(stepLen), .highGate(highGate), .lowGate(lowGate), .running(running),
        .sector(sector)
    );

    function automatic int nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return int'(rngState[31:16]);
    endfunction

    // on-time per frame, clamped to the frame and zero below the minimum pulse
    function automatic int effectiveDuty(input int d);
        if (d < PWM_MIN_ON) return 0;
        if (d > PWM_PERIOD) return PWM_PERIOD;
        return d;
    endfunction

    // low phase is one phase on for even sectors and two phases on for odd ones
    function automatic logic [2:0] lowPattern(input int s);
        return 3'(1 << (((s / 2) + ((s % 2 == 0) ? 1 : 2)) % 3));
    endfunction

    // mix of too short, regular and oversized duty commands
    function automatic int pickDuty();
        int r;
        r = nextRand();
        case (r % 3)
            0: return r % PWM_MIN_ON;
            1: return PWM_MIN_ON + r % (PWM_PERIOD - PWM_MIN_ON + 1);
            default: return PWM_PERIOD + 1 + r % (255 - PWM_PERIOD);
        endcase
    endfunction

    task automatic advanceModel();
        logic stepLastM, pwmM;
        int onM, deadNextM;
        stepLastM = mRunning && mTimer == 0;
        onM = effectiveDuty(mDuty);
        pwmM = mRunning && onM > 0 && mFrame >= PWM_PERIOD - onM;
        // a commutation starts the dead time, otherwise it runs down to zero
        deadNextM = mCommutate ? DEAD_CYCLES : (mDead > 0 ? mDead - 1 : 0);
        if (mRunning && !mCommutate && deadNextM == 0) begin
            mHigh = pwmM ? 3'(1 << (mSector / 2)) : 3'b000;
            mLow = lowPattern(mSector);
        end else begin
            mHigh = 3'b000;
            mLow = 3'b000;
        end
        mDead = deadNextM;
        if (!mRunning || mCommutate || mFrame == PWM_PERIOD - 1) begin
            mFrame = 0;
            mDuty = duty;
        end else begin
            mFrame++;
        end
        mCommutate = stepLastM;
        if (stepLastM) mSector = (mSector + (mDir ? SECTOR_COUNT - 1 : 1)) % SECTOR_COUNT;
        mTimer = (!mRunning || mTimer == 0) ? int'(stepLen) : mTimer - 1;
        if (!mRunning && enable) begin
            mRunning = 1'b1;
            mDir = direction;
        end else if (mRunning && !enable) begin
            mRunning = 1'b0;
        end
    endtask

    always @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            {mTimer, mFrame, mDuty, mDead, mSector} = '0;
            {mRunning, mDir, mCommutate, mHigh, mLow} = '0;
        end else begin
            advanceModel();
        end
    end

    task automatic checkSector(input string name, input logic [SECTOR_W-1:0] got,
                               input logic [SECTOR_W-1:0] exp);
        if (got !== exp) begin
            errCount++;
            $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkGates(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            errCount++;
            $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errCount++;
            $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            errCount++;
            $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // outputs settle after the rising edge, so the falling edge compares them
    always @(negedge clk) begin
        if (nRst === 1'b1) begin
            checkSector("sector", sector, SECTOR_W'(mSector));
            checkGates("highGate", highGate, mHigh);
            checkGates("lowGate", lowGate, mLow);
            checkFlag("running", running, mRunning);
        end
    end

    // returns on the falling edge where sector first differs
    task automatic waitSectorChange(output int cycles);
        logic [SECTOR_W-1:0] oldSector;
        oldSector = sector;
        cycles = 0;
        while (sector === oldSector && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (sector === oldSector) begin
            errCount++;
            $display("no commutation seen within %0d cycles at %0t", WAIT_LIMIT, $time);
        end
    endtask

    // all gates off for the dead time, then the new low phase conducts
    task automatic checkDeadWindow();
        repeat (DEAD_CYCLES) begin
            @(negedge clk);
            checkGates("highGate", highGate, 3'b000);
            checkGates("lowGate", lowGate, 3'b000);
        end
        @(negedge clk);
        checkGates("lowGate", lowGate, lowPattern(sector));
    endtask

    // the direction input toggles every step and must be ignored while running
    task automatic runSteps(input int count, input logic down);
        int cycles;
        logic [SECTOR_W-1:0] prev;
        waitSectorChange(cycles);
        repeat (count) begin
            prev = sector;
            duty = DUTY_W'(nextRand());
            direction = ~direction;
            checkDeadWindow();
            waitSectorChange(cycles);
            checkCount("stepInterval", cycles + DEAD_CYCLES + 1, int'(stepLen) + 1);
            checkSector("sector", sector,
                        SECTOR_W'((prev + (down ? SECTOR_COUNT - 1 : 1)) % SECTOR_COUNT));
        end
    endtask

    // running drops on the next edge, the gates one edge later
    task automatic stopMotor();
        enable = 1'b0;
        @(negedge clk);
        checkFlag("running", running, 1'b0);
        @(negedge clk);
        checkGates("highGate", highGate, 3'b000);
        checkGates("lowGate", lowGate, 3'b000);
    endtask

    // counts high gate cycles over the second frame after each commutation
    task automatic dutyFrames(input int count);
        int cycles, target, onCycles;
        waitSectorChange(cycles);
        repeat (count) begin
            target = pickDuty();
            duty = DUTY_W'(target);
            waitSectorChange(cycles);
            // the first frame loses cycles to the dead time, skip it
            repeat (PWM_PERIOD + 1) @(negedge clk);
            onCycles = 0;
            repeat (PWM_PERIOD) begin
                @(negedge clk);
                if (highGate != 3'b000) onCycles++;
            end
            checkCount("highOnCycles", onCycles, effectiveDuty(target));
        end
    endtask

    // property failures from the bound checker count as errors too
    task automatic collectAssertFails();
        errCount += dut.props.assertFails - assertSeen;
        assertSeen = dut.props.assertFails;
    endtask

    task automatic finishTest(input string name, input int mark);
        collectAssertFails();
        testsRun++;
        if (errCount == mark) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errCount - mark);
        end
    endtask

    initial begin
        int mark, cycles;
        logic [SECTOR_W-1:0] kept;
        enable = 1'b0;
        direction = 1'b0;
        duty = '0;
        stepLen = STEP_W'(16);
        mark = errCount;
        repeat (3) @(negedge clk);
        checkGates("highGate", highGate, 3'b000);
        checkGates("lowGate", lowGate, 3'b000);
        checkFlag("running", running, 1'b0);
        checkSector("sector", sector, '0);
        @(posedge nRst);
        @(negedge clk);
        finishTest("reset", mark);
        mark = errCount;
        stepLen = STEP_W'(10 + nextRand() % 40);
        direction = 1'b0;
        enable = 1'b1;
        runSteps(6, 1'b0);
        stopMotor();
        finishTest("forward run", mark);
        mark = errCount;
        stepLen = STEP_W'(10 + nextRand() % 40);
        direction = 1'b1;
        enable = 1'b1;
        runSteps(6, 1'b1);
        stopMotor();
        finishTest("reverse run", mark);
        mark = errCount;
        stepLen = STEP_W'(MAX_STEP);
        enable = 1'b1;
        dutyFrames(8);
        stopMotor();
        finishTest("duty frames", mark);
        mark = errCount;
        stepLen = STEP_W'(10 + nextRand() % 40);
        direction = 1'b0;
        enable = 1'b1;
        waitSectorChange(cycles);
        stopMotor();
        kept = sector;
        repeat (5) begin
            @(negedge clk);
            checkSector("sector", sector, kept);
        end
        enable = 1'b1;
        waitSectorChange(cycles);
        checkSector("sector", sector, SECTOR_W'((kept + 1) % SECTOR_COUNT));
        stopMotor();
        finishTest("stop and restart", mark);
        $display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCH_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: motorPwm.f
hdl/motorPkg.sv
hdl/driveIf.sv
hdl/commutationTimer.sv
hdl/pwmGenerator.sv
hdl/phaseDriver.sv
hdl/motorCtrl.sv
hdl/motorPwmTop.sv
testbench/clockGen.sv
testbench/motorPwm_props.sv
testbench/motorPwmTb.sv

// File: Bender.yml
package:
  name: motorPwm

sources:
  - files:
      - hdl/motorPkg.sv
      - hdl/driveIf.sv
      - hdl/commutationTimer.sv
      - hdl/pwmGenerator.sv
      - hdl/phaseDriver.sv
      - hdl/motorCtrl.sv
      - hdl/motorPwmTop.sv
  - target: simulation
    files:
      - testbench/clockGen.sv
      - testbench/motorPwm_props.sv
      - testbench/motorPwmTb.sv
